/* verilog/core_pkg.sv */
package core_pkg;

    localparam int XLEN        = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int DMEM_WORDS  = 256;
    localparam int DMEM_ADDR_W = 8;     // Word index, byte address bits [9:2]

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU
    } alu_op_e;

    typedef enum logic [3:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE,
        BR_BLT,
        BR_BGE,
        BR_BLTU,
        BR_BGEU,
        BR_JAL,
        BR_JALR
    } branch_op_e;

    typedef enum logic [3:0] {
        LSU_NONE,
        LSU_LB,
        LSU_LH,
        LSU_LW,
        LSU_LBU,
        LSU_LHU,
        LSU_SB,
        LSU_SH,
        LSU_SW
    } lsu_op_e;

    typedef enum logic [1:0] {
        DEST_ALU,
        DEST_MEM,
        DEST_PC4
    } data_dest_e;

endpackage

/* verilog/exec_stage.sv */
module exec_stage (
    input  logic                       valid_i,
    input  logic [core_pkg::XLEN-1:0]  pc_i,
    input  logic [core_pkg::XLEN-1:0]  rs1_i,
    input  logic [core_pkg::XLEN-1:0]  rs2_i,
    input  logic [core_pkg::XLEN-1:0]  imm_i,
    input  logic                       use_imm_i,
    input  core_pkg::alu_op_e          alu_op_i,
    input  core_pkg::branch_op_e       branch_op_i,

    output logic [core_pkg::XLEN-1:0]  alu_result_o,
    output logic [core_pkg::XLEN-1:0]  pc_plus4_o,
    output logic [core_pkg::XLEN-1:0]  new_pc_o,
    output logic                       br_taken_o
);
    import core_pkg::*;

    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] sum;
    logic [4:0]      shamt;
    logic            is_eq;
    logic            is_lt;
    logic            is_ltu;

    assign op_b   = use_imm_i ? imm_i : rs2_i;
    assign sum    = rs1_i + op_b;   // Shared with JALR target
    assign shamt  = op_b[4:0];

    // Branch compares always use rs2, never the immediate
    assign is_eq  = (rs1_i == rs2_i);
    assign is_lt  = ($signed(rs1_i) < $signed(rs2_i));
    assign is_ltu = (rs1_i < rs2_i);

    assign pc_plus4_o = pc_i + 32'd4;

    always_comb begin
        case (alu_op_i)
            ALU_ADD:  alu_result_o = sum;
            ALU_SUB:  alu_result_o = rs1_i - op_b;
            ALU_AND:  alu_result_o = rs1_i & op_b;
            ALU_OR:   alu_result_o = rs1_i | op_b;
            ALU_XOR:  alu_result_o = rs1_i ^ op_b;
            ALU_SLL:  alu_result_o = rs1_i << shamt;
            ALU_SRL:  alu_result_o = rs1_i >> shamt;
            ALU_SRA:  alu_result_o = $signed(rs1_i) >>> shamt;
            ALU_SLT:  alu_result_o = {{(XLEN-1){1'b0}}, ($signed(rs1_i) < $signed(op_b))};
            ALU_SLTU: alu_result_o = {{(XLEN-1){1'b0}}, (rs1_i < op_b)};
            default:  alu_result_o = '0;
        endcase
    end

    always_comb begin
        case (branch_op_i)
            BR_BEQ:   br_taken_o = is_eq;
            BR_BNE:   br_taken_o = !is_eq;
            BR_BLT:   br_taken_o = is_lt;
            BR_BGE:   br_taken_o = !is_lt;
            BR_BLTU:  br_taken_o = is_ltu;
            BR_BGEU:  br_taken_o = !is_ltu;
            BR_JAL,
            BR_JALR:  br_taken_o = 1'b1;
            default:  br_taken_o = 1'b0;
        endcase
    end

    always_comb begin
        case (branch_op_i)
            BR_NONE:  new_pc_o = pc_plus4_o;         // Fall through
            BR_JALR:  new_pc_o = {sum[XLEN-1:1], 1'b0};
            default:  new_pc_o = pc_i + imm_i;
        endcase
    end

    // Opcode from the issue port must decode to a real ALU operation
    always_comb begin
        if (valid_i) begin
            assert final (alu_op_i inside {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
                                           ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU})
                else $error("Undefined ALU opcode %0h on a valid issue", alu_op_i);
        end
    end

endmodule

/* verilog/ex_mem_register.sv */
module ex_mem_register (
    input  logic                            clk,
    input  logic                            reset_n,

    input  logic                            valid_i,
    input  logic                            hold_i,

    input  logic [core_pkg::XLEN-1:0]       new_pc_i,
    input  logic                            br_taken_i,
    input  logic [core_pkg::XLEN-1:0]       pc_plus4_i,
    input  logic [core_pkg::XLEN-1:0]       alu_result_i,
    input  logic [core_pkg::XLEN-1:0]       rs2_i,
    input  core_pkg::data_dest_e            data_dest_i,
    input  core_pkg::lsu_op_e               lsu_op_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] reg_wr_addr_i,
    input  logic                            reg_wr_sig_i,

    output logic                            valid_o,
    output logic [core_pkg::XLEN-1:0]       new_pc_o,
    output logic                            br_taken_o,
    output logic [core_pkg::XLEN-1:0]       pc_plus4_o,
    output logic [core_pkg::XLEN-1:0]       alu_result_o,
    output logic [core_pkg::XLEN-1:0]       rs2_o,
    output core_pkg::data_dest_e            data_dest_o,
    output core_pkg::lsu_op_e               lsu_op_o,
    output logic [core_pkg::REG_ADDR_W-1:0] reg_wr_addr_o,
    output logic                            reg_wr_sig_o
);
    import core_pkg::*;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            valid_o       <= 1'b0;
            new_pc_o      <= '0;
            br_taken_o    <= 1'b0;
            pc_plus4_o    <= '0;
            alu_result_o  <= '0;
            rs2_o         <= '0;
            data_dest_o   <= DEST_ALU;
            lsu_op_o      <= LSU_NONE;
            reg_wr_addr_o <= '0;
            reg_wr_sig_o  <= 1'b0;
        end else if (!hold_i) begin
            valid_o       <= valid_i;
            new_pc_o      <= new_pc_i;
            br_taken_o    <= br_taken_i;
            pc_plus4_o    <= pc_plus4_i;
            alu_result_o  <= alu_result_i;
            rs2_o         <= rs2_i;
            data_dest_o   <= data_dest_i;
            lsu_op_o      <= lsu_op_i;
            reg_wr_addr_o <= reg_wr_addr_i;
            reg_wr_sig_o  <= reg_wr_sig_i;
        end
    end

    // A stalled instruction must reach the memory stage unchanged
    assert property (@(posedge clk) disable iff (!reset_n)
        hold_i |=> $stable({valid_o, new_pc_o, br_taken_o, pc_plus4_o, alu_result_o,
                            rs2_o, data_dest_o, lsu_op_o, reg_wr_addr_o, reg_wr_sig_o}))
        else $error("EX/MEM contents changed during hold");

endmodule

/* verilog/mem_stage.sv */
module mem_stage (
    input  logic                            clk,
    input  logic                            reset_n,

    input  logic                            valid_i,
    input  logic                            stall_i,

    input  logic [core_pkg::XLEN-1:0]       new_pc_i,
    input  logic                            br_taken_i,
    input  logic [core_pkg::XLEN-1:0]       pc_plus4_i,
    input  logic [core_pkg::XLEN-1:0]       alu_result_i,
    input  logic [core_pkg::XLEN-1:0]       rs2_i,
    input  core_pkg::data_dest_e            data_dest_i,
    input  core_pkg::lsu_op_e               lsu_op_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] rd_i,
    input  logic                            reg_wr_i,

    output logic                            wb_valid_o,
    output logic                            wb_reg_wr_o,
    output logic [core_pkg::REG_ADDR_W-1:0] wb_rd_o,
    output logic [core_pkg::XLEN-1:0]       wb_data_o,
    output logic                            redirect_o,
    output logic [core_pkg::XLEN-1:0]       redirect_pc_o
);
    import core_pkg::*;

    logic [XLEN-1:0]        dmem [DMEM_WORDS];
    logic [DMEM_ADDR_W-1:0] word_idx;
    logic [1:0]             byte_off;
    logic [3:0]             byte_en;
    logic [XLEN-1:0]        st_data;
    logic                   is_store;
    logic                   misaligned;

    logic [XLEN-1:0]        rdata_q;
    logic [XLEN-1:0]        wb_base_q;  // ALU result or PC+4
    data_dest_e             wb_dest_q;
    lsu_op_e                ld_op_q;
    logic [1:0]             ld_off_q;
    logic [XLEN-1:0]        ld_shift;
    logic [XLEN-1:0]        ld_data;

    assign word_idx = alu_result_i[DMEM_ADDR_W+1:2];
    assign byte_off = alu_result_i[1:0];
    assign is_store = lsu_op_i inside {LSU_SB, LSU_SH, LSU_SW};

    always_comb begin
        case (lsu_op_i)
            LSU_SB:  begin byte_en = 4'b0001 << byte_off; st_data = {4{rs2_i[7:0]}};  end
            LSU_SH:  begin byte_en = 4'b0011 << byte_off; st_data = {2{rs2_i[15:0]}}; end
            LSU_SW:  begin byte_en = 4'b1111;             st_data = rs2_i;            end
            default: begin byte_en = 4'b0000;             st_data = rs2_i;            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (valid_i && !stall_i && is_store) begin
            for (int b = 0; b < 4; b++) begin
                if (byte_en[b]) dmem[word_idx][8*b +: 8] <= st_data[8*b +: 8];
            end
        end
        if (!stall_i) rdata_q <= dmem[word_idx];  // Sync read, old data on same-edge write
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wb_valid_o  <= 1'b0;
            wb_reg_wr_o <= 1'b0;
            redirect_o  <= 1'b0;
        end else if (!stall_i) begin
            wb_valid_o  <= valid_i;
            wb_reg_wr_o <= valid_i && reg_wr_i;
            redirect_o  <= valid_i && br_taken_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            wb_rd_o       <= rd_i;
            redirect_pc_o <= new_pc_i;
            wb_base_q     <= (data_dest_i == DEST_PC4) ? pc_plus4_i : alu_result_i;
            wb_dest_q     <= data_dest_i;
            ld_op_q       <= lsu_op_i;
            ld_off_q      <= byte_off;
        end
    end

    // Lane select and extension after the read edge
    assign ld_shift = rdata_q >> {ld_off_q, 3'b000};

    always_comb begin
        case (ld_op_q)
            LSU_LB:  ld_data = {{24{ld_shift[7]}}, ld_shift[7:0]};
            LSU_LBU: ld_data = {24'd0, ld_shift[7:0]};
            LSU_LH:  ld_data = {{16{ld_shift[15]}}, ld_shift[15:0]};
            LSU_LHU: ld_data = {16'd0, ld_shift[15:0]};
            LSU_LW:  ld_data = rdata_q;
            default: ld_data = '0;
        endcase
    end

    assign wb_data_o = (wb_dest_q == DEST_MEM) ? ld_data : wb_base_q;

    assign misaligned = ((lsu_op_i inside {LSU_LH, LSU_LHU, LSU_SH}) && byte_off[0])
                     || ((lsu_op_i inside {LSU_LW, LSU_SW}) && (byte_off != 2'b00));

    // Address comes from the ALU two modules upstream
    assert property (@(posedge clk) disable iff (!reset_n)
        valid_i |-> !misaligned)
        else $error("Misaligned access %0h for lsu op %0d", alu_result_i, lsu_op_i);

endmodule

/* verilog/backend_top.sv */
module backend_top (
    input  logic                            clk,
    input  logic                            reset_n,

    input  logic                            issue_valid_i,
    output logic                            issue_ready_o,
    input  logic [core_pkg::XLEN-1:0]       pc_i,
    input  logic [core_pkg::XLEN-1:0]       rs1_i,
    input  logic [core_pkg::XLEN-1:0]       rs2_i,
    input  logic [core_pkg::XLEN-1:0]       imm_i,
    input  logic                            use_imm_i,
    input  core_pkg::alu_op_e               alu_op_i,
    input  core_pkg::branch_op_e            branch_op_i,
    input  core_pkg::lsu_op_e               lsu_op_i,
    input  core_pkg::data_dest_e            data_dest_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] rd_i,
    input  logic                            reg_wr_i,

    output logic                            wb_valid_o,
    input  logic                            wb_ready_i,
    output logic                            wb_reg_wr_o,
    output logic [core_pkg::REG_ADDR_W-1:0] wb_rd_o,
    output logic [core_pkg::XLEN-1:0]       wb_data_o,
    output logic                            redirect_o,
    output logic [core_pkg::XLEN-1:0]       redirect_pc_o
);
    import core_pkg::*;

    logic                  stall;
    logic                  issue_fire;

    logic [XLEN-1:0]       ex_new_pc;
    logic                  ex_br_taken;
    logic [XLEN-1:0]       ex_pc_plus4;
    logic [XLEN-1:0]       ex_alu_result;

    logic                  mem_valid;
    logic [XLEN-1:0]       mem_new_pc;
    logic                  mem_br_taken;
    logic [XLEN-1:0]       mem_pc_plus4;
    logic [XLEN-1:0]       mem_alu_result;
    logic [XLEN-1:0]       mem_rs2;
    data_dest_e            mem_data_dest;
    lsu_op_e               mem_lsu_op;
    logic [REG_ADDR_W-1:0] mem_rd;
    logic                  mem_reg_wr;

    assign stall         = wb_valid_o && !wb_ready_i;  // Result waiting at the output
    assign issue_ready_o = !stall;
    assign issue_fire    = issue_valid_i && issue_ready_o;

    exec_stage u_exec (
        .valid_i(issue_valid_i), .pc_i(pc_i), .rs1_i(rs1_i), .rs2_i(rs2_i), .imm_i(imm_i),
        .use_imm_i(use_imm_i), .alu_op_i(alu_op_i), .branch_op_i(branch_op_i),
        .alu_result_o(ex_alu_result), .pc_plus4_o(ex_pc_plus4), .new_pc_o(ex_new_pc),
        .br_taken_o(ex_br_taken)
    );

    ex_mem_register u_ex_mem (
        .clk(clk), .reset_n(reset_n), .valid_i(issue_fire), .hold_i(stall),
        .new_pc_i(ex_new_pc), .br_taken_i(ex_br_taken), .pc_plus4_i(ex_pc_plus4),
        .alu_result_i(ex_alu_result), .rs2_i(rs2_i), .data_dest_i(data_dest_i),
        .lsu_op_i(lsu_op_i), .reg_wr_addr_i(rd_i), .reg_wr_sig_i(reg_wr_i),
        .valid_o(mem_valid), .new_pc_o(mem_new_pc), .br_taken_o(mem_br_taken),
        .pc_plus4_o(mem_pc_plus4), .alu_result_o(mem_alu_result), .rs2_o(mem_rs2),
        .data_dest_o(mem_data_dest), .lsu_op_o(mem_lsu_op), .reg_wr_addr_o(mem_rd),
        .reg_wr_sig_o(mem_reg_wr)
    );

    mem_stage u_mem (
        .clk(clk), .reset_n(reset_n), .valid_i(mem_valid), .stall_i(stall),
        .new_pc_i(mem_new_pc), .br_taken_i(mem_br_taken), .pc_plus4_i(mem_pc_plus4),
        .alu_result_i(mem_alu_result), .rs2_i(mem_rs2), .data_dest_i(mem_data_dest),
        .lsu_op_i(mem_lsu_op), .rd_i(mem_rd), .reg_wr_i(mem_reg_wr),
        .wb_valid_o(wb_valid_o), .wb_reg_wr_o(wb_reg_wr_o), .wb_rd_o(wb_rd_o),
        .wb_data_o(wb_data_o), .redirect_o(redirect_o), .redirect_pc_o(redirect_pc_o)
    );

endmodule

/* bench/tb_clock_gen.sv */
module tb_clock_gen (
    output logic clk_o
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk_o = 1'b0;
    end

    always #4 clk_o = ~clk_o;  // 8 ns period

endmodule

/* bench/backend_tb.sv */
module backend_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import core_pkg::*;

    localparam int N_ALU  = 200;
    localparam int N_BR   = 36;
    localparam int N_MEM  = 184;  // 64 fill stores, 60 store/load pairs
    localparam int N_MIX  = 200;
    localparam int N_TPUT = 50;
    localparam int TIMEOUT_CYCLES = 2 * (N_ALU + N_BR + N_MEM + N_MIX + N_TPUT) + 200;

    logic                  clk;
    logic                  reset_n = 1'b1;
    logic                  issue_valid_i;
    logic                  issue_ready_o;
    logic [XLEN-1:0]       pc_i;
    logic [XLEN-1:0]       rs1_i;
    logic [XLEN-1:0]       rs2_i;
    logic [XLEN-1:0]       imm_i;
    logic                  use_imm_i;
    alu_op_e               alu_op_i;
    branch_op_e            branch_op_i;
    lsu_op_e               lsu_op_i;
    data_dest_e            data_dest_i;
    logic [REG_ADDR_W-1:0] rd_i;
    logic                  reg_wr_i;
    logic                  wb_valid_o;
    logic                  wb_ready_i;
    logic                  wb_reg_wr_o;
    logic [REG_ADDR_W-1:0] wb_rd_o;
    logic [XLEN-1:0]       wb_data_o;
    logic                  redirect_o;
    logic [XLEN-1:0]       redirect_pc_o;

    logic [31:0]   model_mem [DMEM_WORDS];
    logic [70:0]   exp_q [$];          // {reg_wr, rd, data, redirect, redirect_pc}
    int            issue_cyc_q [$];    // -1 when latency is not checked
    logic [2047:0] ready_bits;
    logic          bp_mode = 1'b0;
    logic          lat_check = 1'b0;
    int            cycle_count = 0;
    int            err_count = 0;
    int            test_start = 0;
    int            tests_passed = 0;
    int            tests_failed = 0;

    tb_clock_gen clock_gen_i (.clk_o(clk));

    backend_top backend_top_i (.*);

    always @(posedge clk) cycle_count <= cycle_count + 1;

    function automatic logic [70:0] expected_result(
        input logic [31:0] pc, input logic [31:0] rs1, input logic [31:0] rs2,
        input logic [31:0] imm, input logic use_imm, input alu_op_e alu, input branch_op_e br,
        input lsu_op_e lsu, input data_dest_e dest, input logic [4:0] rd, input logic wr);
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] word;
        logic [31:0] load;
        logic [31:0] data;
        logic [31:0] target;
        logic [7:0]  idx;
        logic [1:0]  off;
        logic        taken;
        b = use_imm ? imm : rs2;
        case (alu)
            ALU_ADD:  res = rs1 + b;
            ALU_SUB:  res = rs1 - b;
            ALU_AND:  res = rs1 & b;
            ALU_OR:   res = rs1 | b;
            ALU_XOR:  res = rs1 ^ b;
            ALU_SLL:  res = rs1 << b[4:0];
            ALU_SRL:  res = rs1 >> b[4:0];
            ALU_SRA:  res = $signed(rs1) >>> b[4:0];
            ALU_SLT:  res = ($signed(rs1) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU: res = (rs1 < b) ? 32'd1 : 32'd0;
            default:  res = 32'd0;
        endcase
        case (br)
            BR_BEQ:  taken = (rs1 == rs2);
            BR_BNE:  taken = (rs1 != rs2);
            BR_BLT:  taken = ($signed(rs1) < $signed(rs2));
            BR_BGE:  taken = ($signed(rs1) >= $signed(rs2));
            BR_BLTU: taken = (rs1 < rs2);
            BR_BGEU: taken = (rs1 >= rs2);
            BR_JAL, BR_JALR: taken = 1'b1;
            default: taken = 1'b0;
        endcase
        target = (br == BR_JALR) ? ((rs1 + b) & 32'hFFFF_FFFE) : (pc + imm);
        idx  = res[9:2];
        off  = res[1:0];
        word = model_mem[idx] >> (8 * off);  // Addressed byte moved to lane 0
        case (lsu)
            LSU_LB:  load = {{24{word[7]}}, word[7:0]};
            LSU_LBU: load = {24'd0, word[7:0]};
            LSU_LH:  load = {{16{word[15]}}, word[15:0]};
            LSU_LHU: load = {16'd0, word[15:0]};
            LSU_LW:  load = model_mem[idx];
            LSU_SB:  model_mem[idx][8*off +: 8] = rs2[7:0];
            LSU_SH:  model_mem[idx][8*off +: 16] = rs2[15:0];
            LSU_SW:  model_mem[idx] = rs2;
            default: load = 32'd0;
        endcase
        case (dest)
            DEST_MEM: data = load;
            DEST_PC4: data = pc + 32'd4;
            default:  data = res;
        endcase
        return {wr, rd, data, taken, target};
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            err_count++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_idle_outputs();
        check_value(32'(wb_valid_o), 32'd0, "wb_valid_o in reset");
        check_value(32'(wb_reg_wr_o), 32'd0, "wb_reg_wr_o in reset");
        check_value(32'(redirect_o), 32'd0, "redirect_o in reset");
        check_value(32'(issue_ready_o), 32'd1, "issue_ready_o in reset");
    endtask

    function automatic logic [31:0] random_pc();
        return $urandom() & 32'hFFFF_FFFC;
    endfunction

    function automatic logic [1:0] aligned_off(input lsu_op_e op);
        case (op)
            LSU_LB, LSU_LBU, LSU_SB: return 2'($urandom_range(3));
            LSU_LH, LSU_LHU, LSU_SH: return {1'($urandom_range(1)), 1'b0};
            default: return 2'b00;
        endcase
    endfunction

    // Drive on the falling edge, hold until the DUT accepts
    task automatic issue_instr(input logic [31:0] pc, input logic [31:0] rs1,
        input logic [31:0] rs2, input logic [31:0] imm, input logic use_imm,
        input alu_op_e alu, input branch_op_e br, input lsu_op_e lsu, input data_dest_e dest,
        input logic [4:0] rd, input logic wr);
        @(negedge clk);
        pc_i          = pc;
        rs1_i         = rs1;
        rs2_i         = rs2;
        imm_i         = imm;
        use_imm_i     = use_imm;
        alu_op_i      = alu;
        branch_op_i   = br;
        lsu_op_i      = lsu;
        data_dest_i   = dest;
        rd_i          = rd;
        reg_wr_i      = wr;
        issue_valid_i = 1'b1;
        #1;
        while (!issue_ready_o) begin
            @(negedge clk);
            #1;
        end
        exp_q.push_back(expected_result(pc, rs1, rs2, imm, use_imm, alu, br, lsu, dest, rd, wr));
        issue_cyc_q.push_back(lat_check ? cycle_count : -1);
    endtask

    task automatic alu_instr(input alu_op_e op);
        issue_instr(random_pc(), $urandom(), $urandom(), $urandom(), 1'($urandom_range(1)),
                    op, BR_NONE, LSU_NONE, DEST_ALU, 5'($urandom()), 1'b1);
    endtask

    task automatic branch_instr(input branch_op_e br, input logic [31:0] a,
                                input logic [31:0] b);
        logic jump;
        jump = (br == BR_JAL) || (br == BR_JALR);
        issue_instr(random_pc(), a, b, $urandom() & 32'hFFFF_FFFE, br == BR_JALR, ALU_ADD, br,
                    LSU_NONE, jump ? DEST_PC4 : DEST_ALU, 5'($urandom()), jump);
    endtask

    task automatic mem_access(input lsu_op_e op, input logic [7:0] word,
                              input logic [1:0] off, input logic [31:0] data);
        logic [31:0] addr;
        logic [31:0] imm;
        logic        is_load;
        addr    = {22'd0, word, off};
        imm     = $urandom_range(63) - 32'd32;  // Base plus signed offset
        is_load = op inside {LSU_LB, LSU_LH, LSU_LW, LSU_LBU, LSU_LHU};
        issue_instr(random_pc(), addr - imm, data, imm, 1'b1, ALU_ADD, BR_NONE, op,
                    is_load ? DEST_MEM : DEST_ALU, 5'($urandom()), is_load);
    endtask

    task automatic random_mem(input lsu_op_e op);
        mem_access(op, 8'($urandom_range(63)), aligned_off(op), $urandom());
    endtask

    task automatic end_test(input string name);
        @(negedge clk);
        issue_valid_i = 1'b0;
        while (exp_q.size() != 0) @(negedge clk);
        if (err_count == test_start) begin
            tests_passed++;
            $display("Test %s: done, no errors", name);
        end else begin
            tests_failed++;
            $display("Test %s: done, %0d errors", name, err_count - test_start);
        end
        test_start = err_count;
    endtask

    // Writeback side: ready on the falling edge, compare against the queue
    initial begin : compare_results
        logic [70:0] rec;
        int          issued_at;
        int          last_cyc;
        logic        last_timed;
        wb_ready_i = 1'b0;
        last_cyc   = 0;
        last_timed = 1'b0;
        @(posedge reset_n);
        forever begin
            @(negedge clk);
            wb_ready_i = bp_mode ? ready_bits[cycle_count % 2048] : 1'b1;
            #1;
            check_value(32'(issue_ready_o), 32'(!(wb_valid_o && !wb_ready_i)), "issue_ready_o");
            if (wb_valid_o && wb_ready_i) begin
                if (exp_q.size() == 0) begin
                    err_count++;
                    $display("Unexpected result at %0t ns with nothing outstanding", $time);
                end else begin
                    rec       = exp_q.pop_front();
                    issued_at = issue_cyc_q.pop_front();
                    check_value(32'(wb_reg_wr_o), 32'(rec[70]), "wb_reg_wr_o");
                    if (rec[70]) begin
                        check_value(32'(wb_rd_o), 32'(rec[69:65]), "wb_rd_o");
                        check_value(wb_data_o, rec[64:33], "wb_data_o");
                    end
                    check_value(32'(redirect_o), 32'(rec[32]), "redirect_o");
                    if (rec[32]) check_value(redirect_pc_o, rec[31:0], "redirect_pc_o");
                    if (issued_at >= 0) begin
                        check_value(cycle_count - issued_at, 32'd2, "result latency");
                        if (last_timed) check_value(cycle_count - last_cyc, 32'd1, "result gap");
                    end
                    last_timed = (issued_at >= 0);
                    last_cyc   = cycle_count;
                end
            end
        end
    end

    initial begin : watchdog
        while (cycle_count < TIMEOUT_CYCLES) @(negedge clk);
        $display("Timeout: no finish after %0d cycles, %0d results still outstanding",
                 TIMEOUT_CYCLES, exp_q.size());
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin : run_tests
        logic [31:0] a;
        logic [31:0] b;
        logic [7:0]  word;
        lsu_op_e     st_op;
        issue_valid_i = 1'b0;
        pc_i          = '0;
        rs1_i         = '0;
        rs2_i         = '0;
        imm_i         = '0;
        use_imm_i     = 1'b0;
        alu_op_i      = ALU_ADD;
        branch_op_i   = BR_NONE;
        lsu_op_i      = LSU_NONE;
        data_dest_i   = DEST_ALU;
        rd_i          = '0;
        reg_wr_i      = 1'b0;
        a = $urandom(32'h5da6_c496);
        for (int i = 0; i < 2048; i++) ready_bits[i] = ($urandom_range(3) != 0);

        #1 reset_n = 1'b0;
        repeat (10) begin
            @(negedge clk);
            check_idle_outputs();
        end
        reset_n = 1'b1;
        @(negedge clk);
        #1;
        check_idle_outputs();
        end_test("reset state");

        for (int i = 0; i < N_ALU; i++) alu_instr(alu_op_e'(4'(i % 10)));
        end_test("ALU operations");

        for (int op = 0; op < 9; op++) begin
            for (int p = 0; p < 4; p++) begin
                case (p)
                    0: begin a = $urandom(); b = a; end
                    1: begin a = 32'd5; b = 32'd9; end
                    2: begin a = 32'd9; b = 32'd5; end
                    default: begin a = 32'hFFFF_FFF0; b = 32'h10; end  // Signs disagree
                endcase
                branch_instr(branch_op_e'(4'(op)), a, b);
            end
        end
        end_test("branches and jumps");

        for (int w = 0; w < 64; w++) mem_access(LSU_SW, 8'(w), 2'b00, $urandom());
        for (int i = 0; i < 60; i++) begin
            word  = 8'($urandom_range(63));
            st_op = lsu_op_e'(4'(6 + $urandom_range(2)));
            mem_access(st_op, word, aligned_off(st_op), $urandom());
            mem_access(lsu_op_e'(4'(1 + i % 5)), word, aligned_off(lsu_op_e'(4'(1 + i % 5))),
                       32'd0);
        end
        end_test("loads and stores");

        bp_mode = 1'b1;
        for (int i = 0; i < N_MIX; i++) begin
            case ($urandom_range(3))
                0: alu_instr(alu_op_e'(4'($urandom_range(9))));
                1: branch_instr(branch_op_e'(4'($urandom_range(8))), $urandom(), $urandom());
                2: random_mem(lsu_op_e'(4'(6 + $urandom_range(2))));
                default: random_mem(lsu_op_e'(4'(1 + $urandom_range(4))));
            endcase
        end
        end_test("back-pressure");
        bp_mode = 1'b0;

        lat_check = 1'b1;
        for (int i = 0; i < N_TPUT; i++) alu_instr(alu_op_e'(4'(i % 10)));
        end_test("full throughput");
        lat_check = 1'b0;

        if (exp_q.size() != 0) begin
            err_count++;
            $display("Results missing at the end: %0d still expected", exp_q.size());
        end
        $display("Tests: %0d passed, %0d failed, %0d errors", tests_passed, tests_failed,
                 err_count);
        if (err_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* flist.f */
verilog/core_pkg.sv
verilog/exec_stage.sv
verilog/ex_mem_register.sv
verilog/mem_stage.sv
verilog/backend_top.sv
bench/tb_clock_gen.sv
bench/backend_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the backend testbench with Verilator, run it, then judge the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module backend_tb -f flist.f \
        -o backend_sim > build.log 2>&1 \
    && ./obj_dir/backend_sim > "$LOG" 2>&1 \
    || { cat build.log "$LOG" 2>/dev/null; echo "Build or run did not complete"; exit 1; }

cat "$LOG"

grep -q "SIMULATION FAILED" "$LOG" \
    && { echo "Run failed, see $LOG"; exit 1; } \
    || { echo "Run clean"; exit 0; }
